// ==== verilog/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

`define MIPS_NUM_REGS     32

`define MIPS_OPC_SPECIAL  6'h00
`define MIPS_OPC_ADDI     6'h08
`define MIPS_OPC_ADDIU    6'h09
`define MIPS_OPC_SLTI     6'h0a
`define MIPS_OPC_SLTIU    6'h0b
`define MIPS_OPC_ANDI     6'h0c
`define MIPS_OPC_ORI      6'h0d
`define MIPS_OPC_XORI     6'h0e

`define MIPS_FN_SLL       6'h00
`define MIPS_FN_SRL       6'h02
`define MIPS_FN_SRA       6'h03
`define MIPS_FN_SLLV      6'h04
`define MIPS_FN_SRLV      6'h06
`define MIPS_FN_SRAV      6'h07
`define MIPS_FN_ADD       6'h20
`define MIPS_FN_ADDU      6'h21
`define MIPS_FN_SUB       6'h22
`define MIPS_FN_SUBU      6'h23
`define MIPS_FN_AND       6'h24
`define MIPS_FN_OR        6'h25
`define MIPS_FN_XOR       6'h26
`define MIPS_FN_NOR       6'h27
`define MIPS_FN_SLT       6'h2a
`define MIPS_FN_SLTU      6'h2b

`endif

// ==== verilog/mips_pkg.sv ====
`default_nettype none

package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [5:0]  opc_t;
  typedef logic [5:0]  funct_t;

  // operations seen by the ALU inside ex
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_NOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_PASS_A
  } alu_fn_t;

  typedef enum logic {
    RES_ALU,
    RES_SET
  } res_sel_t;

  typedef enum logic [1:0] {
    SHIFT_LL,  // logical left
    SHIFT_RL,  // logical right
    SHIFT_RA   // arithmetic right
  } shift_kind_t;

endpackage

`default_nettype wire

// ==== verilog/barrel_shifter.sv ====
`timescale 1ns/100ps
`default_nettype none

module barrel_shifter (
  input  wire mips_pkg::word_t        value,
  input  wire mips_pkg::shamt_t       amount,
  input  wire mips_pkg::shift_kind_t  kind,
  output mips_pkg::word_t             shifted
);

  wire mips_pkg::word_t  stage [6];
  wire                   fill;

  assign fill     = (kind == mips_pkg::SHIFT_RA) & value[31];  // sign fill for sra
  assign stage[0] = value;

  // level k shifts by 2**k when amount[k] is set
  for (genvar k = 0; k < 5; k++) begin : g_level
    localparam int N = 1 << k;

    assign stage[k+1] = !amount[k]                  ? stage[k] :
                        (kind == mips_pkg::SHIFT_LL) ? {stage[k][31-N:0], {N{1'b0}}} :
                                                      {{N{fill}}, stage[k][31:N]};
  end

  assign shifted = stage[5];

endmodule

`default_nettype wire

// ==== verilog/ex.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module ex (
  input  wire mips_pkg::word_t   a,
  input  wire mips_pkg::word_t   b,
  input  wire mips_pkg::shamt_t  shamt,
  input  wire mips_pkg::opc_t    opc,
  input  wire mips_pkg::funct_t  funct,
  output mips_pkg::word_t        result
);

  mips_pkg::alu_fn_t      alu_fn;
  mips_pkg::res_sel_t     res_sel;
  mips_pkg::shift_kind_t  shift_kind;
  mips_pkg::shamt_t       shift_amt;
  mips_pkg::word_t        shifted;
  mips_pkg::word_t        alu_res;
  logic                   set_unsigned;
  logic                   var_shift;
  logic                   carry;
  logic                   set_bit;

  always_comb begin
    alu_fn       = mips_pkg::ALU_PASS_A;
    res_sel      = mips_pkg::RES_ALU;
    set_unsigned = 1'b0;
    var_shift    = 1'b0;
    case (opc)
      `MIPS_OPC_SPECIAL: begin
        case (funct)
          `MIPS_FN_SLL: alu_fn = mips_pkg::ALU_SLL;
          `MIPS_FN_SRL: alu_fn = mips_pkg::ALU_SRL;
          `MIPS_FN_SRA: alu_fn = mips_pkg::ALU_SRA;
          `MIPS_FN_SLLV: begin
            alu_fn    = mips_pkg::ALU_SLL;
            var_shift = 1'b1;
          end
          `MIPS_FN_SRLV: begin
            alu_fn    = mips_pkg::ALU_SRL;
            var_shift = 1'b1;
          end
          `MIPS_FN_SRAV: begin
            alu_fn    = mips_pkg::ALU_SRA;
            var_shift = 1'b1;
          end
          `MIPS_FN_ADD, `MIPS_FN_ADDU: alu_fn = mips_pkg::ALU_ADD;  // no overflow trap
          `MIPS_FN_SUB, `MIPS_FN_SUBU: alu_fn = mips_pkg::ALU_SUB;
          `MIPS_FN_AND: alu_fn = mips_pkg::ALU_AND;
          `MIPS_FN_OR:  alu_fn = mips_pkg::ALU_OR;
          `MIPS_FN_XOR: alu_fn = mips_pkg::ALU_XOR;
          `MIPS_FN_NOR: alu_fn = mips_pkg::ALU_NOR;
          `MIPS_FN_SLT: begin
            alu_fn  = mips_pkg::ALU_SUB;
            res_sel = mips_pkg::RES_SET;
          end
          `MIPS_FN_SLTU: begin
            alu_fn       = mips_pkg::ALU_SUB;
            res_sel      = mips_pkg::RES_SET;
            set_unsigned = 1'b1;
          end
          default: ;
        endcase
      end
      `MIPS_OPC_ADDI, `MIPS_OPC_ADDIU: alu_fn = mips_pkg::ALU_ADD;
      `MIPS_OPC_SLTI: begin
        alu_fn  = mips_pkg::ALU_SUB;
        res_sel = mips_pkg::RES_SET;
      end
      `MIPS_OPC_SLTIU: begin
        alu_fn       = mips_pkg::ALU_SUB;
        res_sel      = mips_pkg::RES_SET;
        set_unsigned = 1'b1;
      end
      `MIPS_OPC_ANDI: alu_fn = mips_pkg::ALU_AND;
      `MIPS_OPC_ORI:  alu_fn = mips_pkg::ALU_OR;
      `MIPS_OPC_XORI: alu_fn = mips_pkg::ALU_XOR;
      default: ;
    endcase
  end

  always_comb begin
    case (alu_fn)
      mips_pkg::ALU_SRL: shift_kind = mips_pkg::SHIFT_RL;
      mips_pkg::ALU_SRA: shift_kind = mips_pkg::SHIFT_RA;
      default:           shift_kind = mips_pkg::SHIFT_LL;
    endcase
  end

  assign shift_amt = var_shift ? a[4:0] : shamt;  // sllv/srlv/srav take rs

  barrel_shifter u_shifter (
    .value   (b),
    .amount  (shift_amt),
    .kind    (shift_kind),
    .shifted (shifted)
  );

  always_comb begin
    alu_res = '0;
    carry   = 1'b0;
    case (alu_fn)
      mips_pkg::ALU_ADD: {carry, alu_res} = {1'b0, a} + {1'b0, b};
      mips_pkg::ALU_SUB: {carry, alu_res} = {1'b0, a} - {1'b0, b};  // carry is borrow
      mips_pkg::ALU_AND: alu_res = a & b;
      mips_pkg::ALU_OR:  alu_res = a | b;
      mips_pkg::ALU_XOR: alu_res = a ^ b;
      mips_pkg::ALU_NOR: alu_res = ~(a | b);
      mips_pkg::ALU_SLL, mips_pkg::ALU_SRL, mips_pkg::ALU_SRA: alu_res = shifted;
      default:           alu_res = a;
    endcase
  end

  // signed less-than from differing signs or from the sign of the difference
  assign set_bit = set_unsigned ? carry :
                   (a[31] & ~b[31]) | (~(a[31] ^ b[31]) & alu_res[31]);

  assign result = (res_sel == mips_pkg::RES_SET) ? {31'b0, set_bit} : alu_res;

endmodule

`default_nettype wire

// ==== verilog/inst_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module inst_decode (
  input  wire mips_pkg::word_t    inst,
  output mips_pkg::reg_idx_t      rs,
  output mips_pkg::reg_idx_t      rt,
  output mips_pkg::reg_idx_t      dest,
  output mips_pkg::opc_t          opc,
  output mips_pkg::funct_t        funct,
  output mips_pkg::shamt_t        shamt,
  output mips_pkg::word_t         imm,
  output logic                    use_imm,
  output logic                    dest_valid
);

  mips_pkg::reg_idx_t  rd;
  logic                supported;
  logic                imm_signed;

  assign opc   = inst[31:26];
  assign rs    = inst[25:21];
  assign rt    = inst[20:16];
  assign rd    = inst[15:11];
  assign shamt = inst[10:6];
  assign funct = inst[5:0];

  assign use_imm = (opc != `MIPS_OPC_SPECIAL);
  assign dest    = use_imm ? rt : rd;  // i-type writes rt

  assign imm = imm_signed ? {{16{inst[15]}}, inst[15:0]} : {16'b0, inst[15:0]};

  always_comb begin
    supported  = 1'b0;
    imm_signed = 1'b0;
    case (opc)
      `MIPS_OPC_SPECIAL: begin
        case (funct)
          `MIPS_FN_SLL, `MIPS_FN_SRL, `MIPS_FN_SRA,
          `MIPS_FN_SLLV, `MIPS_FN_SRLV, `MIPS_FN_SRAV:
            supported = 1'b1;
          `MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB, `MIPS_FN_SUBU:
            supported = 1'b1;
          `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_NOR:
            supported = 1'b1;
          `MIPS_FN_SLT, `MIPS_FN_SLTU:
            supported = 1'b1;
          default:
            supported = 1'b0;
        endcase
      end
      `MIPS_OPC_ADDI, `MIPS_OPC_ADDIU, `MIPS_OPC_SLTI, `MIPS_OPC_SLTIU: begin
        supported  = 1'b1;
        imm_signed = 1'b1;  // sltiu compares unsigned but still sign-extends
      end
      `MIPS_OPC_ANDI, `MIPS_OPC_ORI, `MIPS_OPC_XORI:
        supported = 1'b1;
      default:
        supported = 1'b0;  // loads, branches etc.
    endcase
  end

  assign dest_valid = supported && (dest != '0);

endmodule

`default_nettype wire

// ==== verilog/reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module reg_file (
  input  wire                      clock,
  input  wire                      reset,
  input  wire mips_pkg::reg_idx_t  rd_addr_a,
  input  wire mips_pkg::reg_idx_t  rd_addr_b,
  input  wire mips_pkg::reg_idx_t  wr_addr,
  input  wire                      wr_en,
  input  wire mips_pkg::word_t     wr_data,
  output mips_pkg::word_t          rd_data_a,
  output mips_pkg::word_t          rd_data_b
);

  mips_pkg::word_t  regs [`MIPS_NUM_REGS];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin  // r0 stays zero
      regs[wr_addr] <= wr_data;
    end
  end

  // plain async reads
  assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
  assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire

// ==== verilog/int_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module int_core (
  input  wire                   clock,
  input  wire                   reset,
  input  wire                   inst_valid,
  input  wire mips_pkg::word_t  inst,
  input  wire mips_pkg::word_t  pc,  // carried along but unused by execute
  output logic                  wb_valid,
  output mips_pkg::reg_idx_t    wb_reg,
  output mips_pkg::word_t       wb_data
);

  logic                dec_valid;
  mips_pkg::word_t     dec_inst;

  mips_pkg::reg_idx_t  rs;
  mips_pkg::reg_idx_t  rt;
  mips_pkg::reg_idx_t  dest;
  mips_pkg::opc_t      opc;
  mips_pkg::funct_t    funct;
  mips_pkg::shamt_t    shamt;
  mips_pkg::word_t     imm;
  logic                use_imm;
  logic                dest_valid;

  mips_pkg::word_t     rf_a;
  mips_pkg::word_t     rf_b;
  mips_pkg::word_t     op_a;
  mips_pkg::word_t     rt_val;
  mips_pkg::word_t     op_b;
  mips_pkg::word_t     result;

  always_ff @(posedge clock) begin
    if (reset) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
    end
  end

  always_ff @(posedge clock) begin
    dec_inst <= inst;
  end

  inst_decode u_decode (
    .inst       (dec_inst),
    .rs         (rs),
    .rt         (rt),
    .dest       (dest),
    .opc        (opc),
    .funct      (funct),
    .shamt      (shamt),
    .imm        (imm),
    .use_imm    (use_imm),
    .dest_valid (dest_valid)
  );

  reg_file u_regs (
    .clock     (clock),
    .reset     (reset),
    .rd_addr_a (rs),
    .rd_addr_b (rt),
    .wr_addr   (wb_reg),
    .wr_en     (wb_valid),
    .wr_data   (wb_data),
    .rd_data_a (rf_a),
    .rd_data_b (rf_b)
  );

  // writeback bypass needs no r0 test as wb_valid never flags r0
  assign op_a   = (wb_valid && (wb_reg == rs)) ? wb_data : rf_a;
  assign rt_val = (wb_valid && (wb_reg == rt)) ? wb_data : rf_b;
  assign op_b   = use_imm ? imm : rt_val;

  ex u_ex (
    .a      (op_a),
    .b      (op_b),
    .shamt  (shamt),
    .opc    (opc),
    .funct  (funct),
    .result (result)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= dec_valid & dest_valid;
    end
  end

  always_ff @(posedge clock) begin
    wb_reg  <= dest;
    wb_data <= result;
  end

endmodule

`default_nettype wire

// ==== sim/int_core_properties.sv ====
`timescale 1ns/100ps
`default_nettype none

module int_core_props (
  input wire                      clock,
  input wire                      reset,
  input wire                      inst_valid,
  input wire                      wb_valid,
  input wire mips_pkg::reg_idx_t  wb_reg
);

  a_quiet_in_reset: assert property (@(posedge clock) reset |=> !wb_valid)
    else $error("wb_valid high during reset");

  // pipeline still empty one cycle after release
  a_quiet_after_reset: assert property (@(posedge clock)
    (!reset && $past(reset, 2)) |-> !wb_valid)
    else $error("wb_valid high in the cycle after reset");

  a_no_r0_write: assert property (@(posedge clock) disable iff (reset)
    wb_valid |-> (wb_reg != 5'd0))
    else $error("writeback to register 0");

  a_two_cycle_latency: assert property (@(posedge clock) disable iff (reset)
    wb_valid |-> $past(inst_valid, 2))
    else $error("writeback without an instruction two cycles earlier");

endmodule

bind int_core int_core_props props0 (
  .clock      (clock),
  .reset      (reset),
  .inst_valid (inst_valid),
  .wb_valid   (wb_valid),
  .wb_reg     (wb_reg)
);

`default_nettype wire

// ==== sim/int_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "mips_params.svh"

module int_core_tb;

  localparam int MAX_CYCLES = 2000;  // about ten times the length of the tests

  logic                clock;
  logic                reset;
  logic                inst_valid;
  mips_pkg::word_t     inst;
  mips_pkg::word_t     pc;
  logic                wb_valid;
  mips_pkg::reg_idx_t  wb_reg;
  mips_pkg::word_t     wb_data;

  mips_pkg::word_t     model_regs [`MIPS_NUM_REGS];
  logic [37:0]         exp_q [$];  // one {valid, reg, data} entry per cycle
  int                  cycle_count = 0;
  int                  check_count = 0;
  int                  error_count = 0;

  int_core dut0 (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  initial clock = 1'b0;
  always #2 clock = ~clock;

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // outputs are stable at the falling edge
  always @(negedge clock) begin
    logic [37:0] e;
    if (exp_q.size() > 2) begin
      e = exp_q.pop_front();
      check_count++;
      assert (wb_valid === e[37]) else begin
        error_count++;
        $display("error: wb_valid is %h, expected %h", wb_valid, e[37]);
      end
      if (e[37]) begin
        assert (wb_reg === e[36:32]) else begin
          error_count++;
          $display("error: wb_reg is %h, expected %h", wb_reg, e[36:32]);
        end
        assert (wb_data === e[31:0]) else begin
          error_count++;
          $display("error: wb_data is %h, expected %h", wb_data, e[31:0]);
        end
      end
    end
  end

  function automatic mips_pkg::word_t r_op(mips_pkg::funct_t fn, mips_pkg::reg_idx_t rd,
      mips_pkg::reg_idx_t rs, mips_pkg::reg_idx_t rt, mips_pkg::shamt_t sh);
    return {`MIPS_OPC_SPECIAL, rs, rt, rd, sh, fn};
  endfunction

  function automatic mips_pkg::word_t i_op(mips_pkg::opc_t opc, mips_pkg::reg_idx_t rt,
      mips_pkg::reg_idx_t rs, logic [15:0] imm);
    return {opc, rs, rt, imm};
  endfunction

  // architectural result of one instruction and the register model update
  function automatic logic [37:0] predict(mips_pkg::word_t w);
    mips_pkg::word_t     a;
    mips_pkg::word_t     b;
    mips_pkg::word_t     simm;
    mips_pkg::word_t     zimm;
    mips_pkg::word_t     res;
    mips_pkg::reg_idx_t  dst;
    mips_pkg::shamt_t    sh;
    logic                ok;
    a    = model_regs[w[25:21]];
    b    = model_regs[w[20:16]];
    simm = {{16{w[15]}}, w[15:0]};
    zimm = {16'h0000, w[15:0]};
    sh   = w[10:6];
    dst  = (w[31:26] == `MIPS_OPC_SPECIAL) ? w[15:11] : w[20:16];
    res  = '0;
    ok   = 1'b1;
    case (w[31:26])
      `MIPS_OPC_SPECIAL:
        case (w[5:0])
          `MIPS_FN_SLL:  res = b << sh;
          `MIPS_FN_SRL:  res = b >> sh;
          `MIPS_FN_SRA:  res = $signed(b) >>> sh;
          `MIPS_FN_SLLV: res = b << a[4:0];
          `MIPS_FN_SRLV: res = b >> a[4:0];
          `MIPS_FN_SRAV: res = $signed(b) >>> a[4:0];
          `MIPS_FN_ADD, `MIPS_FN_ADDU: res = a + b;
          `MIPS_FN_SUB, `MIPS_FN_SUBU: res = a - b;
          `MIPS_FN_AND:  res = a & b;
          `MIPS_FN_OR:   res = a | b;
          `MIPS_FN_XOR:  res = a ^ b;
          `MIPS_FN_NOR:  res = ~(a | b);
          `MIPS_FN_SLT:  res = {31'b0, $signed(a) < $signed(b)};
          `MIPS_FN_SLTU: res = {31'b0, a < b};
          default:       ok = 1'b0;
        endcase
      `MIPS_OPC_ADDI, `MIPS_OPC_ADDIU: res = a + simm;
      `MIPS_OPC_SLTI:  res = {31'b0, $signed(a) < $signed(simm)};
      `MIPS_OPC_SLTIU: res = {31'b0, a < simm};
      `MIPS_OPC_ANDI:  res = a & zimm;
      `MIPS_OPC_ORI:   res = a | zimm;
      `MIPS_OPC_XORI:  res = a ^ zimm;
      default:         ok = 1'b0;
    endcase
    ok = ok && (dst != 5'd0);
    if (ok) model_regs[dst] = res;
    return {ok, dst, res};
  endfunction

  task automatic issue(input mips_pkg::word_t w);
    @(posedge clock);
    inst_valid <= 1'b1;
    inst       <= w;
    pc         <= pc + 32'd4;
    exp_q.push_back(predict(w));
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      inst_valid <= 1'b0;
      inst       <= $urandom();  // junk that must be ignored
      exp_q.push_back('0);
    end
  endtask

  // full word via addiu then sll 16 then ori with each step forwarded
  task automatic load_reg(input mips_pkg::reg_idx_t r, input mips_pkg::word_t v);
    issue(i_op(`MIPS_OPC_ADDIU, r, 5'd0, v[31:16]));
    issue(r_op(`MIPS_FN_SLL, r, 5'd0, r, 5'd16));
    issue(i_op(`MIPS_OPC_ORI, r, r, v[15:0]));
  endtask

  task automatic test_reg_alu();
    mips_pkg::funct_t fns [8];
    fns = '{`MIPS_FN_ADD, `MIPS_FN_ADDU, `MIPS_FN_SUB, `MIPS_FN_SUBU,
            `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_XOR, `MIPS_FN_NOR};
    for (int r = 1; r <= 8; r++) load_reg(5'(r), $urandom());
    for (int k = 0; k < 3; k++) begin
      foreach (fns[i]) issue(r_op(fns[i], 5'($urandom_range(15, 9)),
                                  5'($urandom_range(8, 1)), 5'($urandom_range(8, 1)), 5'd0));
    end
  endtask

  task automatic test_immediates();
    mips_pkg::opc_t ops [7];
    ops = '{`MIPS_OPC_ADDI, `MIPS_OPC_ADDIU, `MIPS_OPC_SLTI, `MIPS_OPC_SLTIU,
            `MIPS_OPC_ANDI, `MIPS_OPC_ORI, `MIPS_OPC_XORI};
    load_reg(5'd1, $urandom());
    foreach (ops[i]) begin
      issue(i_op(ops[i], 5'd10, 5'd1, 16'hfff0));  // negative immediate
      issue(i_op(ops[i], 5'd11, 5'd1, 16'h7fff));
      issue(i_op(ops[i], 5'd12, 5'd1, 16'($urandom())));
    end
  endtask

  task automatic test_shifts();
    mips_pkg::shamt_t amts [4];
    amts = '{5'd0, 5'd1, 5'd31, 5'($urandom_range(30, 2))};
    load_reg(5'd2, 32'h8000_0000 | $urandom());
    load_reg(5'd3, $urandom() & 32'h7fff_ffff);
    foreach (amts[i]) begin
      issue(r_op(`MIPS_FN_SLL, 5'd17, 5'd0, 5'd2, amts[i]));
      issue(r_op(`MIPS_FN_SRL, 5'd17, 5'd0, 5'd2, amts[i]));
      issue(r_op(`MIPS_FN_SRA, 5'd17, 5'd0, 5'd2, amts[i]));
      issue(r_op(`MIPS_FN_SRA, 5'd17, 5'd0, 5'd3, amts[i]));
    end
    for (int k = 0; k < 4; k++) begin
      load_reg(5'd4, $urandom());  // amount from rs[4:0]
      issue(r_op(`MIPS_FN_SLLV, 5'd18, 5'd4, 5'd2, 5'd0));
      issue(r_op(`MIPS_FN_SRLV, 5'd18, 5'd4, 5'd2, 5'd0));
      issue(r_op(`MIPS_FN_SRAV, 5'd18, 5'd4, 5'd2, 5'd0));
    end
  endtask

  task automatic slt_pair(input mips_pkg::reg_idx_t rs, input mips_pkg::reg_idx_t rt);
    issue(r_op(`MIPS_FN_SLT, 5'd20, rs, rt, 5'd0));
    issue(r_op(`MIPS_FN_SLTU, 5'd21, rs, rt, 5'd0));
  endtask

  task automatic slti_pair(input mips_pkg::reg_idx_t rs, input logic [15:0] imm);
    issue(i_op(`MIPS_OPC_SLTI, 5'd22, rs, imm));
    issue(i_op(`MIPS_OPC_SLTIU, 5'd23, rs, imm));
  endtask

  task automatic test_set_less_than();
    load_reg(5'd5, 32'h8000_0000);
    load_reg(5'd6, 32'h0000_0001);
    load_reg(5'd7, 32'hffff_ffff);
    slt_pair(5'd5, 5'd6);
    slt_pair(5'd6, 5'd5);
    slt_pair(5'd6, 5'd6);
    slt_pair(5'd7, 5'd0);
    slt_pair(5'd0, 5'd7);
    slti_pair(5'd5, 16'h0001);
    slti_pair(5'd7, 16'h0000);
    slti_pair(5'd0, 16'hffff);  // -1 signed and all ones unsigned
    slti_pair(5'd6, 16'h0001);
  endtask

  task automatic test_forwarding();
    load_reg(5'd1, $urandom());
    for (int k = 0; k < 4; k++) begin
      issue(i_op(`MIPS_OPC_ADDIU, 5'd1, 5'd1, 16'($urandom())));
      issue(r_op(`MIPS_FN_SUBU, 5'd2, 5'd1, 5'd3, 5'd0));  // rs forwarded
      issue(r_op(`MIPS_FN_XOR, 5'd3, 5'd4, 5'd2, 5'd0));   // rt forwarded
    end
    issue(i_op(`MIPS_OPC_ADDIU, 5'd24, 5'd0, 16'h1234));
    issue(i_op(`MIPS_OPC_ADDIU, 5'd25, 5'd0, 16'h8005));
    issue(r_op(`MIPS_FN_ADDU, 5'd26, 5'd24, 5'd25, 5'd0));  // r24 at distance two
    issue(r_op(`MIPS_FN_ADDU, 5'd0, 5'd1, 5'd2, 5'd0));
    issue(i_op(`MIPS_OPC_ADDIU, 5'd0, 5'd0, 16'h0055));
    issue(r_op(`MIPS_FN_OR, 5'd27, 5'd0, 5'd0, 5'd0));
    issue(r_op(`MIPS_FN_ADDU, 5'd28, 5'd0, 5'd1, 5'd0));
  endtask

  task automatic test_gaps();
    issue(i_op(6'h23, 5'd9, 5'd1, 16'h0004));  // lw
    issue(r_op(6'h3f, 5'd9, 5'd1, 5'd2, 5'd0));
    issue(i_op(`MIPS_OPC_ADDIU, 5'd9, 5'd1, 16'h0001));
    idle(1);
    issue(r_op(`MIPS_FN_ADDU, 5'd10, 5'd9, 5'd9, 5'd0));
    idle(3);
    issue(r_op(`MIPS_FN_XOR, 5'd11, 5'd10, 5'd9, 5'd0));
    issue(i_op(6'h23, 5'd11, 5'd0, 16'h0000));  // must not touch r11
    issue(r_op(`MIPS_FN_OR, 5'd12, 5'd11, 5'd0, 5'd0));
  endtask

  initial begin
    void'($urandom(32'h2be0));
    reset      = 1'b1;
    inst_valid = 1'b1;  // valid traffic while in reset must be dropped
    inst       = i_op(`MIPS_OPC_ADDIU, 5'd1, 5'd0, 16'h0001);
    pc         = '0;
    foreach (model_regs[i]) model_regs[i] = '0;
    repeat (16) @(posedge clock);
    reset      <= 1'b0;
    inst_valid <= 1'b0;
    test_reg_alu();
    test_immediates();
    test_shifts();
    test_set_less_than();
    test_forwarding();
    test_gaps();
    idle(4);
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verilog
verilog/mips_pkg.sv
verilog/barrel_shifter.sv
verilog/ex.sv
verilog/inst_decode.sv
verilog/reg_file.sv
verilog/int_core.sv
sim/int_core_properties.sv
sim/int_core_tb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := int_core_tb
FILELIST  := sources.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG       := sim.log

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) verilog/mips_params.svh

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
